// ==== include/audio_consts.svh ====
// Audio processor constants

`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

// Datapath widths
`define AUDIO_SAMPLE_W 16
`define AUDIO_COEFF_W 16
`define AUDIO_VOL_W 8
`define AUDIO_ACC_W 34  // Four 32-bit products summed

// Filter shape
`define AUDIO_TAPS 4
`define AUDIO_SHIFT 8   // Fixed point scale, 256 is unity

// Coefficients loaded at reset, tap 0 is the newest sample
`define AUDIO_COEFF_DEFAULT_0 16'd128
`define AUDIO_COEFF_DEFAULT_1 16'd64
`define AUDIO_COEFF_DEFAULT_2 16'd32
`define AUDIO_COEFF_DEFAULT_3 16'd16

// Downstream credits
`define AUDIO_OUT_CREDITS_MAX 4

`endif

// ==== src/audio_data_pkg.sv ====
// Audio datapath types

package audio_data_pkg;

    `include "audio_consts.svh"

    // Plain widths
    typedef logic [`AUDIO_SAMPLE_W-1:0] sample_t;
    typedef logic [`AUDIO_COEFF_W-1:0]  coeff_t;
    typedef logic [`AUDIO_VOL_W-1:0]    volume_t;   // 256 would be unity
    typedef logic [1:0]                 tap_idx_t;  // History or coefficient slot

    // One left/right pair
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // Coefficient write request
    typedef struct packed {
        logic     we;
        tap_idx_t idx;
        coeff_t   data;
    } coeff_wr_t;

endpackage

// ==== src/audio_ctrl_pkg.sv ====
// Audio controller types

package audio_ctrl_pkg;

    `include "audio_consts.svh"

    // Per-sample sequencing
    typedef enum logic [1:0] {
        IDLE,    // Waiting for a sample
        FILTER,  // FIR step
        SCALE,   // Volume step
        OUTPUT   // Waiting for a downstream credit
    } flow_state_t;

    // Holds 0 to AUDIO_OUT_CREDITS_MAX
    typedef logic [$clog2(`AUDIO_OUT_CREDITS_MAX+1)-1:0] credit_cnt_t;

endpackage

// ==== src/audio_sample_history.sv ====
// Stereo sample history

`timescale 1ns/10ps

`include "audio_consts.svh"

module audio_sample_history (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we_i,
    input  audio_data_pkg::stereo_t sample_i,
    output audio_data_pkg::stereo_t taps_o [`AUDIO_TAPS]
);

    audio_data_pkg::stereo_t  entries [`AUDIO_TAPS];
    audio_data_pkg::tap_idx_t wr_ptr;  // Next slot to write

    // Circular store
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            for (int k = 0; k < `AUDIO_TAPS; k++) begin
                entries[k] <= '0;
            end
        end else if (we_i) begin
            entries[wr_ptr] <= sample_i;
            wr_ptr          <= wr_ptr + 2'd1;  // Wraps after four
        end
    end

    // Newest entry sits just behind the write pointer
    always_comb begin
        for (int k = 0; k < `AUDIO_TAPS; k++) begin
            taps_o[k] = entries[wr_ptr - audio_data_pkg::tap_idx_t'(k + 1)];
        end
    end

endmodule

// ==== src/audio_fir_filter.sv ====
// Four-tap stereo FIR filter

`timescale 1ns/10ps

`include "audio_consts.svh"

module audio_fir_filter (
    input  logic                      clk,
    input  logic                      rst,
    input  audio_data_pkg::coeff_wr_t coeff_wr_i,
    input  logic                      en_i,
    input  audio_data_pkg::stereo_t   taps_i [`AUDIO_TAPS],
    output audio_data_pkg::stereo_t   result_o
);

    audio_data_pkg::coeff_t   coeff_q [`AUDIO_TAPS];
    logic [`AUDIO_ACC_W-1:0]  acc_left;
    logic [`AUDIO_ACC_W-1:0]  acc_right;

    // Coefficient register file
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            coeff_q[0] <= `AUDIO_COEFF_DEFAULT_0;
            coeff_q[1] <= `AUDIO_COEFF_DEFAULT_1;
            coeff_q[2] <= `AUDIO_COEFF_DEFAULT_2;
            coeff_q[3] <= `AUDIO_COEFF_DEFAULT_3;
        end else if (coeff_wr_i.we) begin
            coeff_q[coeff_wr_i.idx] <= coeff_wr_i.data;
        end
    end

    // Sum of products, unsigned
    always_comb begin
        acc_left  = '0;
        acc_right = '0;
        for (int k = 0; k < `AUDIO_TAPS; k++) begin
            acc_left  = acc_left + `AUDIO_ACC_W'(taps_i[k].left) * `AUDIO_ACC_W'(coeff_q[k]);
            acc_right = acc_right + `AUDIO_ACC_W'(taps_i[k].right) * `AUDIO_ACC_W'(coeff_q[k]);
        end
    end

    // Shift down and keep the low sample bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_o <= '0;
        end else if (en_i) begin
            result_o.left  <= acc_left[`AUDIO_SHIFT +: `AUDIO_SAMPLE_W];
            result_o.right <= acc_right[`AUDIO_SHIFT +: `AUDIO_SAMPLE_W];
        end
    end

endmodule

// ==== src/audio_volume_scaler.sv ====
// Stereo volume stage

`timescale 1ns/10ps

`include "audio_consts.svh"

module audio_volume_scaler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cap_i,
    input  audio_data_pkg::volume_t volume_i,
    input  logic                    en_i,
    input  audio_data_pkg::stereo_t sample_i,
    output audio_data_pkg::stereo_t sample_o
);

    audio_data_pkg::volume_t                   vol_q;  // Gain of the sample in flight
    logic [`AUDIO_SAMPLE_W+`AUDIO_VOL_W-1:0]   prod_left;
    logic [`AUDIO_SAMPLE_W+`AUDIO_VOL_W-1:0]   prod_right;

    assign prod_left  = sample_i.left * vol_q;
    assign prod_right = sample_i.right * vol_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vol_q    <= '0;
            sample_o <= '0;
        end else begin
            if (cap_i) begin
                vol_q <= volume_i;  // Latched with the sample
            end
            if (en_i) begin
                sample_o.left  <= prod_left[`AUDIO_SHIFT +: `AUDIO_SAMPLE_W];
                sample_o.right <= prod_right[`AUDIO_SHIFT +: `AUDIO_SAMPLE_W];
            end
        end
    end

endmodule

// ==== src/audio_flow_ctrl.sv ====
// Sample sequencing and credit control

`timescale 1ns/10ps

`include "audio_consts.svh"

module audio_flow_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic in_valid_i,
    input  logic out_credit_i,
    output logic in_credit_o,
    output logic out_valid_o,
    output logic hist_we_o,
    output logic vol_cap_o,
    output logic fir_en_o,
    output logic vol_en_o
);

    localparam audio_ctrl_pkg::credit_cnt_t CREDIT_MAX =
        audio_ctrl_pkg::credit_cnt_t'(`AUDIO_OUT_CREDITS_MAX);

    audio_ctrl_pkg::flow_state_t state_q;
    audio_ctrl_pkg::flow_state_t state_d;
    audio_ctrl_pkg::credit_cnt_t credit_q;
    audio_ctrl_pkg::credit_cnt_t credit_d;
    logic                        started_q;  // First clock after reset seen
    logic                        init_q;     // Initial credit pulse
    logic                        accept;

    assign accept      = (state_q == audio_ctrl_pkg::IDLE) && in_valid_i;
    assign hist_we_o   = accept;
    assign vol_cap_o   = accept;
    assign fir_en_o    = (state_q == audio_ctrl_pkg::FILTER);
    assign vol_en_o    = (state_q == audio_ctrl_pkg::SCALE);
    assign out_valid_o = (state_q == audio_ctrl_pkg::OUTPUT) && (credit_q != '0);
    assign in_credit_o = init_q || out_valid_o;  // Credit returns with the output

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            audio_ctrl_pkg::IDLE:   if (in_valid_i) state_d = audio_ctrl_pkg::FILTER;
            audio_ctrl_pkg::FILTER: state_d = audio_ctrl_pkg::SCALE;
            audio_ctrl_pkg::SCALE:  state_d = audio_ctrl_pkg::OUTPUT;
            audio_ctrl_pkg::OUTPUT: if (out_valid_o) state_d = audio_ctrl_pkg::IDLE;
            default:                state_d = audio_ctrl_pkg::IDLE;
        endcase
    end

    // Grant and use in one cycle cancel out
    always_comb begin
        credit_d = credit_q;
        if (out_credit_i && !out_valid_o) begin
            if (credit_q != CREDIT_MAX) begin
                credit_d = credit_q + 1'b1;
            end
        end else if (out_valid_o && !out_credit_i) begin
            credit_d = credit_q - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= audio_ctrl_pkg::IDLE;
            credit_q  <= '0;
            started_q <= 1'b0;
            init_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            credit_q  <= credit_d;
            started_q <= 1'b1;
            init_q    <= !started_q;  // High for one cycle only
        end
    end

endmodule

// ==== src/audio_proc_top.sv ====
// Stereo audio sample processor

`timescale 1ns/10ps

`include "audio_consts.svh"

module audio_proc_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid_i,
    input  audio_data_pkg::stereo_t   in_sample_i,
    input  audio_data_pkg::volume_t   volume_i,
    output logic                      in_credit_o,
    input  audio_data_pkg::coeff_wr_t coeff_wr_i,
    input  logic                      out_credit_i,
    output logic                      out_valid_o,
    output audio_data_pkg::stereo_t   out_sample_o
);

    logic                    hist_we;
    logic                    vol_cap;
    logic                    fir_en;
    logic                    vol_en;
    audio_data_pkg::stereo_t taps [`AUDIO_TAPS];  // Newest first
    audio_data_pkg::stereo_t filt_sample;

    audio_flow_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .out_credit_i (out_credit_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .hist_we_o    (hist_we),
        .vol_cap_o    (vol_cap),
        .fir_en_o     (fir_en),
        .vol_en_o     (vol_en)
    );

    audio_sample_history hist_i (
        .clk      (clk),
        .rst      (rst),
        .we_i     (hist_we),
        .sample_i (in_sample_i),
        .taps_o   (taps)
    );

    audio_fir_filter fir_i (
        .clk        (clk),
        .rst        (rst),
        .coeff_wr_i (coeff_wr_i),
        .en_i       (fir_en),
        .taps_i     (taps),
        .result_o   (filt_sample)
    );

    // Scaler register drives the output pair directly
    audio_volume_scaler vol_i (
        .clk      (clk),
        .rst      (rst),
        .cap_i    (vol_cap),
        .volume_i (volume_i),
        .en_i     (vol_en),
        .sample_i (filt_sample),
        .sample_o (out_sample_o)
    );

endmodule

// ==== verification/audio_proc_tb.sv ====
// Audio processor testbench
// Random stimulus against a behavioral model

`timescale 1ns/10ps

`include "audio_consts.svh"

module audio_proc_tb;

    localparam int N_RANDOM    = 200;
    localparam int N_IMPULSE   = 9;
    localparam int N_HOLD      = 2 * (`AUDIO_OUT_CREDITS_MAX + 1);
    localparam int N_COEFF     = 40;
    localparam int N_SAMPLES   = N_RANDOM + N_IMPULSE + N_HOLD + N_COEFF;
    localparam int CYCLE_LIMIT = 20 * N_SAMPLES + 200;

    localparam int GRANT_NONE   = 0;
    localparam int GRANT_RANDOM = 1;
    localparam int GRANT_ALL    = 2;

    logic                      clk;
    logic                      rst;
    logic                      in_valid_i;
    audio_data_pkg::stereo_t   in_sample_i;
    audio_data_pkg::volume_t   volume_i;
    logic                      in_credit_o;
    audio_data_pkg::coeff_wr_t coeff_wr_i;
    logic                      out_credit_i;
    logic                      out_valid_o;
    audio_data_pkg::stereo_t   out_sample_o;

    integer                    seed;
    int                        grant_mode;   // Sink behavior
    int                        cycle_cnt;
    int                        out_cnt;
    int                        ic_cnt;       // in_credit_o pulses seen
    int                        src_credits;  // Held by the source
    int                        m_credit;     // DUT output credits
    logic                      m_busy;       // Sample in flight
    int                        m_age;        // Edges since accept
    audio_data_pkg::stereo_t   m_hist [`AUDIO_TAPS];  // Newest first
    audio_data_pkg::coeff_t    m_coeff [`AUDIO_TAPS];
    audio_data_pkg::stereo_t   exp_q [$];
    logic                      req_valid;
    audio_data_pkg::stereo_t   req_sample;
    audio_data_pkg::volume_t   req_vol;
    audio_data_pkg::coeff_wr_t req_coeff;

    audio_proc_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .in_sample_i  (in_sample_i),
        .volume_i     (volume_i),
        .in_credit_o  (in_credit_o),
        .coeff_wr_i   (coeff_wr_i),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_sample_o (out_sample_o)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[FAIL] %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    // FIR over the model history, then volume
    function automatic audio_data_pkg::stereo_t predict(input audio_data_pkg::volume_t vol);
        logic [63:0]             acc_l;
        logic [63:0]             acc_r;
        logic [63:0]             filt_l;
        logic [63:0]             filt_r;
        audio_data_pkg::stereo_t res;
        acc_l = '0;
        acc_r = '0;
        for (int k = 0; k < `AUDIO_TAPS; k++) begin
            acc_l = acc_l + 64'(m_hist[k].left) * 64'(m_coeff[k]);
            acc_r = acc_r + 64'(m_hist[k].right) * 64'(m_coeff[k]);
        end
        filt_l    = (acc_l >> `AUDIO_SHIFT) & 64'hffff;
        filt_r    = (acc_r >> `AUDIO_SHIFT) & 64'hffff;
        res.left  = 16'((filt_l * 64'(vol)) >> `AUDIO_SHIFT);
        res.right = 16'((filt_r * 64'(vol)) >> `AUDIO_SHIFT);
        return res;
    endfunction

    // Result waits in OUTPUT with no credit to spend
    function automatic logic stalled();
        return m_busy && (m_age >= 2) && (m_credit == 0);
    endfunction

    // One clock: check the cycle that ended, update the model, drive the next
    task automatic step();
        logic                    v;
        logic                    ic;
        logic                    exp_v;
        logic                    exp_ic;
        logic [31:0]             r;
        audio_data_pkg::stereo_t exp_s;
        @(posedge clk);
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            fail_run("Timeout, the tests did not finish within the cycle limit");
        end
        v      = out_valid_o;
        ic     = in_credit_o;
        exp_v  = m_busy && (m_age >= 2) && (m_credit != 0);
        exp_ic = exp_v || (cycle_cnt == 2);  // Initial credit follows reset release
        if (v && !exp_v) fail_run("Output pulse arrived when none was expected");
        if (!v && exp_v) fail_run("Expected output pulse did not arrive");
        if (ic && !exp_ic) fail_run("Input credit pulse arrived when none was expected");
        if (!ic && exp_ic) fail_run("Expected input credit pulse did not arrive");
        if (v) begin
            exp_s = exp_q.pop_front();
            compare("out_sample_o.left", 32'(exp_s.left), 32'(out_sample_o.left));
            compare("out_sample_o.right", 32'(exp_s.right), 32'(out_sample_o.right));
            out_cnt++;
        end
        if (out_credit_i && !v) begin
            if (m_credit < `AUDIO_OUT_CREDITS_MAX) m_credit++;  // Saturates
        end else if (v && !out_credit_i) begin
            m_credit--;
        end
        if (ic) begin
            ic_cnt++;
            src_credits++;
            if (src_credits > 1) fail_run("Source was granted more than one input credit");
        end
        if (v) m_busy = 1'b0;
        else if (m_busy) m_age++;

        r = $random(seed);
        in_valid_i <= req_valid;
        if (req_valid) begin
            if (src_credits == 0) fail_run("Source tried to send without an input credit");
            if (m_busy) fail_run("Source tried to send while a sample was in flight");
            src_credits--;
            in_sample_i <= req_sample;
            volume_i    <= req_vol;
            for (int k = `AUDIO_TAPS - 1; k > 0; k--) begin
                m_hist[k] = m_hist[k - 1];
            end
            m_hist[0] = req_sample;
            exp_q.push_back(predict(req_vol));
            m_busy = 1'b1;
            m_age  = -1;  // Accepted on the next edge
        end else begin
            in_sample_i <= audio_data_pkg::stereo_t'(r);  // Junk to be ignored
            volume_i    <= r[7:0];
        end
        coeff_wr_i <= req_coeff;
        if (req_coeff.we) m_coeff[req_coeff.idx] = req_coeff.data;
        case (grant_mode)
            GRANT_ALL:    out_credit_i <= 1'b1;
            GRANT_RANDOM: out_credit_i <= r[20];
            default:      out_credit_i <= 1'b0;
        endcase
        req_valid = 1'b0;
        req_coeff = '0;
    endtask

    task automatic send_sample(input logic [15:0] left, input logic [15:0] right,
                               input audio_data_pkg::volume_t vol);
        while (src_credits == 0) step();
        req_valid        = 1'b1;
        req_sample.left  = left;
        req_sample.right = right;
        req_vol          = vol;
        step();
    endtask

    task automatic send_random();
        send_sample(16'($random(seed)), 16'($random(seed)), 8'($random(seed)));
    endtask

    task automatic write_coeff(input audio_data_pkg::tap_idx_t idx, input logic [15:0] data);
        req_coeff.we   = 1'b1;
        req_coeff.idx  = idx;
        req_coeff.data = data;
        step();
    endtask

    task automatic wait_idle();
        while (m_busy || src_credits == 0) step();
    endtask

    // Send until a result gets stuck
    task automatic drain_credits();
        for (int i = 0; i <= `AUDIO_OUT_CREDITS_MAX; i++) begin
            if (!stalled()) begin
                send_random();
                while (m_busy && !stalled()) step();
            end
        end
        if (!stalled()) fail_run("Output did not stall after downstream credits ran out");
    endtask

    initial begin
        seed         = 32'h3f6a_d125;
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid_i   = 1'b0;
        in_sample_i  = '0;
        volume_i     = '0;
        coeff_wr_i   = '0;
        out_credit_i = 1'b0;
        grant_mode   = GRANT_NONE;
        cycle_cnt    = 0;
        out_cnt      = 0;
        ic_cnt       = 0;
        src_credits  = 0;
        m_credit     = 0;
        m_busy       = 1'b0;
        m_age        = 0;
        req_valid    = 1'b0;
        req_sample   = '0;
        req_vol      = '0;
        req_coeff    = '0;
        for (int k = 0; k < `AUDIO_TAPS; k++) begin
            m_hist[k] = '0;
        end
        m_coeff[0] = `AUDIO_COEFF_DEFAULT_0;
        m_coeff[1] = `AUDIO_COEFF_DEFAULT_1;
        m_coeff[2] = `AUDIO_COEFF_DEFAULT_2;
        m_coeff[3] = `AUDIO_COEFF_DEFAULT_3;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Quiet start, a single credit and no output
        repeat (8) step();
        compare("input credits after reset", 32'd1, 32'(src_credits));

        // Impulse walks the default taps, history wraps twice
        grant_mode = GRANT_ALL;
        send_sample(16'h0100, 16'h0200, 8'h80);
        repeat (N_IMPULSE - 1) send_sample(16'h0000, 16'h0000, 8'h80);
        wait_idle();

        grant_mode = GRANT_RANDOM;
        repeat (N_RANDOM) send_random();
        wait_idle();

        // Sink stall, then more grants than the counter holds
        grant_mode = GRANT_NONE;
        drain_credits();
        repeat (20) step();
        grant_mode = GRANT_ALL;
        repeat (`AUDIO_OUT_CREDITS_MAX + 3) step();
        grant_mode = GRANT_NONE;
        drain_credits();
        grant_mode = GRANT_RANDOM;
        wait_idle();

        // Fresh coefficients between bursts
        repeat (4) begin
            for (int k = 0; k < `AUDIO_TAPS; k++) begin
                write_coeff(audio_data_pkg::tap_idx_t'(k), 16'($random(seed)));
            end
            repeat (N_COEFF / 4) send_random();
            wait_idle();
        end

        compare("in_credit_o pulse count", 32'(out_cnt + 1), 32'(ic_cnt));
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
src/audio_data_pkg.sv
src/audio_ctrl_pkg.sv
src/audio_sample_history.sv
src/audio_fir_filter.sv
src/audio_volume_scaler.sv
src/audio_flow_ctrl.sv
src/audio_proc_top.sv
verification/audio_proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/audio_proc_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary -Wno-fatal -f files.f --top-module audio_proc_tb -o audio_proc_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "No verdict found in $LOG"
    exit 1
fi

echo "Simulation PASSED"
exit 0
